//--- src/fcu_pkg.sv
/*
  Flow control unit shared definitions
  Word and field types, opcode and function encodings, stage bundles
*/

package fcu_pkg;

  // ==========================================================
  // Plain vector types
  // ==========================================================

  // Data word, also the width of every address operand
  typedef logic [63:0] word_t;
  // Full instruction as delivered by fetch
  typedef logic [39:0] instr_t;
  // Operating level, 3 is user
  typedef logic [1:0]  ol_t;
  // Interrupt mask level
  typedef logic [3:0]  im_t;
  // Index of one condition bit within a word
  typedef logic [5:0]  bitsel_t;

  localparam ol_t OL_USER = 2'd3;

  // Result for anything the unit does not recognise
  localparam word_t FILL_WORD = {16{4'hC}};

  // ==========================================================
  // Instruction field positions
  // ==========================================================

  localparam int OPC_LSB    = 0;
  localparam int OPC_MSB    = 5;
  localparam int FN_LSB     = 6;
  localparam int FN_MSB     = 9;
  localparam int DST_LSB    = 8;
  localparam int DST_MSB    = 13;
  localparam int SRC1_LSB   = 14;
  localparam int SRC1_MSB   = 19;
  localparam int SRC2_LSB   = 20;
  localparam int SRC2_MSB   = 25;
  localparam int CRFN_LSB   = 26;
  localparam int CRFN_MSB   = 28;
  // BRK cause byte
  localparam int CAUSE_LSB  = 22;
  localparam int CAUSE_MSB  = 29;
  // RTS offset, counted in 16 byte units
  localparam int RTSOFF_LSB = 23;
  localparam int RTSOFF_MSB = 39;

  // ==========================================================
  // Encodings
  // ==========================================================

  // Major opcode, instruction bits 5..0
  typedef enum logic [5:0] {
    BMISC  = 6'h10,
    JRL    = 6'h11,
    JSR    = 6'h12,
    RTS    = 6'h13,
    REX    = 6'h14,
    BMISC2 = 6'h15
  } opcode_e;

  // Minor function, instruction bits 9..6
  // BRK lives under BMISC, WAIT and CRLOG under BMISC2
  typedef enum logic [3:0] {
    BRK   = 4'h0,
    WAIT  = 4'h4,
    CRLOG = 4'h8
  } bfunct_e;

  // Condition register logic function, instruction bits 28..26
  typedef enum logic [2:0] {
    CRAND  = 3'd0,
    CROR   = 3'd1,
    CRXOR  = 3'd2,
    CRANDC = 3'd3,
    CRNAND = 3'd4,
    CRNOR  = 3'd5,
    CRXNOR = 3'd6,
    CRORC  = 3'd7
  } crfn_e;

  // ==========================================================
  // Stage bundles
  // ==========================================================

  // One issued operation with all of its operands
  typedef struct packed {
    instr_t instr;
    word_t  a;
    word_t  tvec;
    word_t  nextpc;
    word_t  waitctr;
    im_t    im;
    ol_t    ol;
  } fcu_op_t;

  // Operation with its instruction fields already split out
  typedef struct packed {
    fcu_op_t op;
    opcode_e opcode;
    bfunct_e funct;
    crfn_e   crfn;
    bitsel_t dst;
    bitsel_t src1;
    bitsel_t src2;
  } fcu_dec_t;

  // Value written back plus its flags
  typedef struct packed {
    word_t result;
    logic  redirect;
    logic  illegal;
  } fcu_res_t;

endpackage

//--- src/fcu_issue.sv
/*
  Flow control unit issue stage
  Captures an issued operation and splits out its instruction fields
*/

`timescale 1ns/10ps

module fcu_issue (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              issue,
  input  fcu_pkg::fcu_op_t  op,
  output logic              dec_valid,
  output fcu_pkg::fcu_dec_t dec
);

  // Held copy of the last issued operation
  fcu_pkg::fcu_op_t op_q;

  // ==========================================================
  // Issue register
  // ==========================================================

  // Valid follows issue by one cycle, one pulse per issue
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dec_valid <= 1'b0;
    end
    else
    begin
      dec_valid <= issue;
    end
  end

  // Operand capture, a new issue may land every cycle
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      op_q <= op;
    end
  end

  // ==========================================================
  // Field split
  // ==========================================================

  always_comb
  begin
    dec.op     = op_q;
    // Opcode and minor function
    dec.opcode = fcu_pkg::opcode_e'(op_q.instr[fcu_pkg::OPC_MSB:fcu_pkg::OPC_LSB]);
    dec.funct  = fcu_pkg::bfunct_e'(op_q.instr[fcu_pkg::FN_MSB:fcu_pkg::FN_LSB]);
    // CR logic function, only meaningful under CRLOG
    dec.crfn   = fcu_pkg::crfn_e'(op_q.instr[fcu_pkg::CRFN_MSB:fcu_pkg::CRFN_LSB]);
    // Condition bit selects
    dec.dst    = op_q.instr[fcu_pkg::DST_MSB:fcu_pkg::DST_LSB];
    dec.src1   = op_q.instr[fcu_pkg::SRC1_MSB:fcu_pkg::SRC1_LSB];
    dec.src2   = op_q.instr[fcu_pkg::SRC2_MSB:fcu_pkg::SRC2_LSB];
  end

endmodule

//--- src/fcu_calc.sv
/*
  Flow control unit calculation
  Result word, redirect and illegal flags for one decoded operation
*/

`timescale 1ns/10ps

module fcu_calc (
  input  fcu_pkg::fcu_dec_t dec,
  output fcu_pkg::fcu_res_t calc
);

  // Immediate fields that only feed the result word
  logic [7:0]        cause;
  logic [16:0]       rts_off;
  // Mask limit for the exception return test
  fcu_pkg::im_t      rex_lim;
  // Condition bit operands and the combined bit
  logic              src1_bit;
  logic              src2_bit;
  logic              cr_bit;
  fcu_pkg::word_t    cr_word;

  assign cause   = dec.op.instr[fcu_pkg::CAUSE_MSB:fcu_pkg::CAUSE_LSB];
  assign rts_off = dec.op.instr[fcu_pkg::RTSOFF_MSB:fcu_pkg::RTSOFF_LSB];

  // Invert of level with two zero bits appended
  assign rex_lim = ~{dec.op.ol, 2'b00};

  assign src1_bit = dec.op.a[dec.src1];
  assign src2_bit = dec.op.a[dec.src2];

  // ==========================================================
  // Condition register logic
  // ==========================================================

  // All eight 3 bit codes are defined functions
  always_comb
  begin
    cr_bit = 1'b0;
    case (dec.crfn)
      fcu_pkg::CRAND:  cr_bit =   src1_bit &  src2_bit;
      fcu_pkg::CROR:   cr_bit =   src1_bit |  src2_bit;
      fcu_pkg::CRXOR:  cr_bit =   src1_bit ^  src2_bit;
      fcu_pkg::CRANDC: cr_bit =   src1_bit & ~src2_bit;
      fcu_pkg::CRNAND: cr_bit = ~(src1_bit &  src2_bit);
      fcu_pkg::CRNOR:  cr_bit = ~(src1_bit |  src2_bit);
      fcu_pkg::CRXNOR: cr_bit = ~(src1_bit ^  src2_bit);
      fcu_pkg::CRORC:  cr_bit =   src1_bit | ~src2_bit;
    endcase
  end

  // Copy of a with only the destination bit replaced
  always_comb
  begin
    cr_word           = dec.op.a;
    cr_word[dec.dst]  = cr_bit;
  end

  // ==========================================================
  // Result select
  // ==========================================================

  always_comb
  begin
    // Unknown encodings fall through to the fill pattern
    calc.result   = fcu_pkg::FILL_WORD;
    calc.redirect = 1'b0;
    calc.illegal  = 1'b1;
    case (dec.opcode)
      fcu_pkg::BMISC:
        if (dec.funct == fcu_pkg::BRK)
        begin
          // Low byte of a merged with the cause
          calc.result  = {56'd0, dec.op.a[7:0] | cause};
          calc.illegal = 1'b0;
        end
      fcu_pkg::JRL,
      fcu_pkg::JSR:
        begin
          // Link address only, the jump itself is resolved upstream
          calc.result  = dec.op.nextpc;
          calc.illegal = 1'b0;
        end
      fcu_pkg::RTS:
        begin
          calc.result   = dec.op.a + fcu_pkg::word_t'({rts_off, 4'h0});
          calc.redirect = 1'b1;
          calc.illegal  = 1'b0;
        end
      fcu_pkg::REX:
        // Not allowed from user level
        if (dec.op.ol != fcu_pkg::OL_USER)
        begin
          calc.result   = (dec.op.im < rex_lim) ? dec.op.tvec : dec.op.nextpc;
          calc.redirect = 1'b1;
          calc.illegal  = 1'b0;
        end
      fcu_pkg::BMISC2:
        case (dec.funct)
          fcu_pkg::WAIT:
            begin
              // Done flag once the counter reaches one
              calc.result  = fcu_pkg::word_t'(dec.op.waitctr == fcu_pkg::word_t'(1));
              calc.illegal = 1'b0;
            end
          fcu_pkg::CRLOG:
            begin
              calc.result  = cr_word;
              calc.illegal = 1'b0;
            end
          default:
            calc.illegal = 1'b1;
        endcase
      default:
        calc.illegal = 1'b1;
    endcase
  end

endmodule

//--- src/fcu_result.sv
/*
  Flow control unit result stage
  Registers the result bundle and drives the done and redirect strobes
*/

`timescale 1ns/10ps

module fcu_result (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              dec_valid,
  input  fcu_pkg::fcu_res_t calc,
  output logic              done,
  output fcu_pkg::fcu_res_t res,
  output logic              redirect_valid
);

  // ==========================================================
  // Strobes
  // ==========================================================

  // One done pulse per valid operation
  // Redirect pulses only alongside done
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      done           <= 1'b0;
      redirect_valid <= 1'b0;
    end
    else
    begin
      done           <= dec_valid;
      redirect_valid <= dec_valid & calc.redirect;
    end
  end

  // ==========================================================
  // Result register
  // ==========================================================

  // Holds the last result between operations
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      res <= '0;
    end
    else if (dec_valid)
    begin
      res <= calc;
    end
  end

endmodule

//--- src/fcu_top.sv
/*
  Flow control unit top level
  Issue register, result calculation and result register in sequence
*/

`timescale 1ns/10ps

module fcu_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              issue,
  input  fcu_pkg::fcu_op_t  op,
  output logic              done,
  output fcu_pkg::fcu_res_t res,
  output logic              redirect_valid
);

  // Issue stage to calculation
  logic              dec_valid;
  fcu_pkg::fcu_dec_t dec;
  // Calculation to result stage
  fcu_pkg::fcu_res_t calc;

  // First cycle, operand capture
  fcu_issue u_issue (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (issue),
    .op        (op),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  // Pure logic between the two registers
  fcu_calc u_calc (
    .dec  (dec),
    .calc (calc)
  );

  // Second cycle, result capture and strobes
  fcu_result u_result (
    .clk            (clk),
    .rst_n          (rst_n),
    .dec_valid      (dec_valid),
    .calc           (calc),
    .done           (done),
    .res            (res),
    .redirect_valid (redirect_valid)
  );

endmodule

//--- bench/fcu_asserts.sv
/*
  Flow control unit protocol assertions
  Strobe timing and result flag rules, bound into the top level
*/

`timescale 1ns/10ps

module fcu_asserts (
  input logic              clk,
  input logic              rst_n,
  input logic              issue,
  input logic              done,
  input logic              redirect_valid,
  input fcu_pkg::fcu_res_t res
);

  // Fixed two cycle latency from issue to done
  done_latency: assert property (@(posedge clk) disable iff (!rst_n)
    done == $past(issue, 2))
    else $error("done does not follow issue by two cycles");

  // Redirect strobe only rides on a done
  redirect_with_done: assert property (@(posedge clk) redirect_valid |-> done)
    else $error("redirect_valid high without done");

  // An illegal result never redirects fetch
  flags_exclusive: assert property (@(posedge clk) !(res.illegal && res.redirect))
    else $error("result marked both illegal and redirect");

  quiet_in_reset: assert property (@(posedge clk) !rst_n |-> (!done && !redirect_valid))
    else $error("output strobe high during reset");

endmodule

bind fcu_top fcu_asserts u_asserts (
  .clk            (clk),
  .rst_n          (rst_n),
  .issue          (issue),
  .done           (done),
  .redirect_valid (redirect_valid),
  .res            (res)
);

//--- bench/fcu_vectors.svh
/*
  Flow control unit vector table
  Columns are instruction, a, waitctr, im, ol, then expected result, redirect, illegal
*/

  // tvec and nextpc are always TVEC and NPC
  // Lines 2 to 5 also feed the back to back test
  function automatic void load_vectors();
    // ==========================================================
    // Link and return
    // ==========================================================
    add_vec(simple_instr(fcu_pkg::JSR, 4'h0), 64'h1111, '0, 4'h0, 2'd0, NPC, 1'b0, 1'b0);
    add_vec(simple_instr(fcu_pkg::JRL, 4'h0), 64'h2222, '0, 4'h0, 2'd0, NPC, 1'b0, 1'b0);
    add_vec(rts_instr(17'h3), 64'h1000, '0, 4'h0, 2'd0, 64'h1030, 1'b1, 1'b0);
    // Offset wraps a negative base
    add_vec(rts_instr(17'h1ffff), 64'hffff_ffff_ffff_fff0, '0, 4'h0, 2'd0,
            64'h0000_0000_001f_ffe0, 1'b1, 1'b0);
    // ==========================================================
    // Exception return, limit is ~{ol, 2'b00}
    // ==========================================================
    add_vec(simple_instr(fcu_pkg::REX, 4'h0), '0, '0, 4'd14, 2'd0, TVEC, 1'b1, 1'b0);
    add_vec(simple_instr(fcu_pkg::REX, 4'h0), '0, '0, 4'd15, 2'd0, NPC, 1'b1, 1'b0);
    add_vec(simple_instr(fcu_pkg::REX, 4'h0), '0, '0, 4'd10, 2'd1, TVEC, 1'b1, 1'b0);
    add_vec(simple_instr(fcu_pkg::REX, 4'h0), '0, '0, 4'd11, 2'd1, NPC, 1'b1, 1'b0);
    add_vec(simple_instr(fcu_pkg::REX, 4'h0), '0, '0, 4'd6, 2'd2, TVEC, 1'b1, 1'b0);
    add_vec(simple_instr(fcu_pkg::REX, 4'h0), '0, '0, 4'd7, 2'd2, NPC, 1'b1, 1'b0);
    // User level may not return from an exception
    add_vec(simple_instr(fcu_pkg::REX, 4'h0), '0, '0, 4'd0, 2'd3, FILL, 1'b0, 1'b1);
    // ==========================================================
    // Break, wait and CR logic
    // ==========================================================
    add_vec(brk_instr(8'h40), 64'h5, '0, 4'h0, 2'd0, 64'h45, 1'b0, 1'b0);
    add_vec(brk_instr(8'h81), 64'hdead_beef_0000_0012, '0, 4'h0, 2'd0, 64'h93, 1'b0, 1'b0);
    add_vec(simple_instr(fcu_pkg::BMISC2, fcu_pkg::WAIT), '0, 64'd0, 4'h0, 2'd0,
            64'd0, 1'b0, 1'b0);
    add_vec(simple_instr(fcu_pkg::BMISC2, fcu_pkg::WAIT), '0, 64'd1, 4'h0, 2'd0,
            64'd1, 1'b0, 1'b0);
    add_vec(simple_instr(fcu_pkg::BMISC2, fcu_pkg::WAIT), '0, 64'd2, 4'h0, 2'd0,
            64'd0, 1'b0, 1'b0);
    add_vec(simple_instr(fcu_pkg::BMISC2, fcu_pkg::WAIT), '0, 64'h1_0000_0001, 4'h0, 2'd0,
            64'd0, 1'b0, 1'b0);
    // Bits 1 and 2 ANDed into bit 34
    add_vec(cr_instr(fcu_pkg::CRAND, 6'd2, 6'd1, 6'h22), 64'h6, '0, 4'h0, 2'd0,
            64'h0000_0004_0000_0006, 1'b0, 1'b0);
    // ==========================================================
    // Illegal encodings
    // ==========================================================
    add_vec(simple_instr(6'h3f, 4'h0), '0, '0, 4'h0, 2'd0, FILL, 1'b0, 1'b1);
    add_vec(simple_instr(fcu_pkg::BMISC, 4'h4), '0, '0, 4'h0, 2'd0, FILL, 1'b0, 1'b1);
    add_vec(simple_instr(fcu_pkg::BMISC2, 4'h1), '0, '0, 4'h0, 2'd0, FILL, 1'b0, 1'b1);
    add_vec(simple_instr(fcu_pkg::BMISC2, 4'h0), '0, '0, 4'h0, 2'd0, FILL, 1'b0, 1'b1);
    // Every 3 bit code is a defined CR function, so none is illegal there
  endfunction

//--- bench/fcu_tb.sv
/*
  Flow control unit testbench
  Vector table, random CR logic operations and back to back issue
*/

`timescale 1ns/10ps

module fcu_tb;

  localparam int TIMEOUT_CYCLES = 20;
  // Table lines reused for the back to back test
  localparam int PIPE_FIRST = 2;
  localparam int PIPE_OPS   = 4;
  localparam fcu_pkg::word_t TVEC = 64'hffff_ffff_fffc_0000;
  localparam fcu_pkg::word_t NPC  = 64'h0000_0000_0000_4000;
  localparam fcu_pkg::word_t FILL = fcu_pkg::FILL_WORD;

  // One table line, operation and its expected result
  typedef struct packed {
    fcu_pkg::fcu_op_t  op;
    fcu_pkg::fcu_res_t exp;
  } vec_t;

  logic              clk;
  logic              rst_n;
  logic              issue;
  fcu_pkg::fcu_op_t  op;
  logic              done;
  fcu_pkg::fcu_res_t res;
  logic              redirect_valid;

  vec_t        vecs[$];
  logic [31:0] lfsr;
  int          i;

  fcu_top dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .issue          (issue),
    .op             (op),
    .done           (done),
    .res            (res),
    .redirect_valid (redirect_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==========================================================
  // Stimulus construction
  // ==========================================================

  function automatic fcu_pkg::instr_t simple_instr(input logic [5:0] opc, input logic [3:0] fn);
    return {30'd0, fn, opc};
  endfunction

  // Offset sits in bits 39..23
  function automatic fcu_pkg::instr_t rts_instr(input logic [16:0] off);
    return {off, 17'd0, fcu_pkg::RTS};
  endfunction

  // Cause sits in bits 29..22
  function automatic fcu_pkg::instr_t brk_instr(input logic [7:0] cause);
    return {10'd0, cause, 12'd0, fcu_pkg::BRK, fcu_pkg::BMISC};
  endfunction

  // Function field covers destination bits 9..8, so d[1:0] reads back as 2'b10
  function automatic fcu_pkg::instr_t cr_instr(input logic [2:0] fn,
      input fcu_pkg::bitsel_t s2, input fcu_pkg::bitsel_t s1, input fcu_pkg::bitsel_t d);
    return {11'd0, fn, s2, s1, d[5:2], fcu_pkg::CRLOG, fcu_pkg::BMISC2};
  endfunction

  function automatic void add_vec(input fcu_pkg::instr_t instr, input fcu_pkg::word_t a,
      input fcu_pkg::word_t waitctr, input fcu_pkg::im_t im, input fcu_pkg::ol_t ol,
      input fcu_pkg::word_t result, input logic redirect, input logic illegal);
    vec_t v;
    v.op  = '{instr, a, TVEC, NPC, waitctr, im, ol};
    v.exp = '{result, redirect, illegal};
    vecs.push_back(v);
  endfunction

  `include "fcu_vectors.svh"

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic fcu_pkg::word_t random_bits(input int n);
    fcu_pkg::word_t r;
    logic           fb;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[62:0], fb};
    end
    return r;
  endfunction

  // Truth table per CR function, indexed by {src1, src2}
  function automatic logic cr_expect(input logic [2:0] fn, input logic x, input logic y);
    logic [3:0] tt;
    case (fn)
      fcu_pkg::CRAND:  tt = 4'b1000;
      fcu_pkg::CROR:   tt = 4'b1110;
      fcu_pkg::CRXOR:  tt = 4'b0110;
      fcu_pkg::CRANDC: tt = 4'b0100;
      fcu_pkg::CRNAND: tt = 4'b0111;
      fcu_pkg::CRNOR:  tt = 4'b0001;
      fcu_pkg::CRXNOR: tt = 4'b1001;
      default:         tt = 4'b1101;
    endcase
    return tt[{x, y}];
  endfunction

  // ==========================================================
  // Checking and handshake
  // ==========================================================

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_res(input fcu_pkg::fcu_res_t exp, input string what);
    check({what, " done"}, 64'(done), 64'd1);
    check({what, " res.result"}, res.result, exp.result);
    check({what, " res.redirect"}, 64'(res.redirect), 64'(exp.redirect));
    check({what, " res.illegal"}, 64'(res.illegal), 64'(exp.illegal));
    check({what, " redirect_valid"}, 64'(redirect_valid), 64'(exp.redirect));
  endtask

  // Polled on falling edges so done is settled
  task automatic wait_done(input string what);
    int n;
    n = 0;
    while (done !== 1'b1)
    begin
      if (n == TIMEOUT_CYCLES)
      begin
        $display("Timed out after %0d cycles waiting for done on %s", n, what);
        $display("TEST FAILED");
        $fatal(1);
      end
      else
      begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  // Single issue, then wait for its result
  task automatic run_op(input fcu_pkg::fcu_op_t o, input fcu_pkg::fcu_res_t exp,
      input string what);
    @(negedge clk);
    issue = 1'b1;
    op    = o;
    @(negedge clk);
    issue = 1'b0;
    wait_done(what);
    check_res(exp, what);
  endtask

  // Random a and bit selects for every CR function
  task automatic crlog_random_test();
    fcu_pkg::fcu_op_t  o;
    fcu_pkg::fcu_res_t exp;
    fcu_pkg::word_t    a;
    fcu_pkg::bitsel_t  s1;
    fcu_pkg::bitsel_t  s2;
    fcu_pkg::bitsel_t  d;
    int                fn;
    int                n;
    for (fn = 0; fn < 8; fn++)
    begin
      for (n = 0; n < 4; n++)
      begin
        a  = random_bits(64);
        s1 = fcu_pkg::bitsel_t'(random_bits(6));
        s2 = fcu_pkg::bitsel_t'(random_bits(6));
        d  = {4'(random_bits(4)), 2'b10};
        o  = '{cr_instr(3'(fn), s2, s1, d), a, TVEC, NPC, 64'd0, 4'd0, 2'd0};
        exp.result    = a;
        exp.result[d] = cr_expect(3'(fn), a[s1], a[s2]);
        exp.redirect  = 1'b0;
        exp.illegal   = 1'b0;
        run_op(o, exp, $sformatf("crlog fn %0d pass %0d", fn, n));
      end
    end
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================

  initial
  begin
    rst_n = 1'b0;
    issue = 1'b0;
    op    = '0;
    lfsr  = 32'hedc38aca;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Outputs stay quiet until the first issue
    repeat (3)
    begin
      @(negedge clk);
      check("idle done", 64'(done), 64'd0);
      check("idle redirect_valid", 64'(redirect_valid), 64'd0);
      check("idle res.result", res.result, 64'd0);
    end

    load_vectors();
    for (i = 0; i < vecs.size(); i++)
      run_op(vecs[i].op, vecs[i].exp, $sformatf("vector %0d", i));
    crlog_random_test();

    // Back to back issue, each done lands exactly two cycles later
    for (i = 0; i < PIPE_OPS + 2; i++)
    begin
      @(negedge clk);
      if (i >= 2)
        check_res(vecs[PIPE_FIRST + i - 2].exp, $sformatf("pipelined op %0d", i - 2));
      else
        check("pipelined early done", 64'(done), 64'd0);
      issue = (i < PIPE_OPS);
      if (i < PIPE_OPS)
        op = vecs[PIPE_FIRST + i].op;
    end
    @(negedge clk);
    check("pipelined trailing done", 64'(done), 64'd0);

    $display("TEST OK");
    $finish;
  end

endmodule

//--- src.f
+incdir+bench
src/fcu_pkg.sv
src/fcu_issue.sv
src/fcu_calc.sv
src/fcu_result.sv
src/fcu_top.sv
bench/fcu_asserts.sv
bench/fcu_tb.sv

//--- Makefile
# Verilator build and run for the flow control unit testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = fcu_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
